//--- Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert
TOP      := mbox_tb
FILELIST := vlog.f
OBJDIR   := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the log decides the result, not the simulator exit code
run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || { echo "simulation ended early"; exit 1; }
	@echo "simulation PASSED"

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- design/mbox_fifo.sv
// mailbox FIFO: one-direction circular buffer with flush and fill count
`timescale 1ns/1ps
`include "mbox_defines.svh"

module mbox_fifo (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     flush_i,  // drop all entries, wins over push/pop
  input  logic                     push_i,   // never asserted while full
  input  logic [`MBOX_DATA_W-1:0]  data_i,
  input  logic                     pop_i,    // never asserted while empty
  output logic [`MBOX_DATA_W-1:0]  data_o,   // oldest entry
  output logic [`MBOX_USAGE_W-1:0] usage_o   // number of stored words
);

  localparam int PTR_W = $clog2(`MBOX_DEPTH);

  logic [`MBOX_DATA_W-1:0]  mem [`MBOX_DEPTH];
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [`MBOX_USAGE_W-1:0] count;

  // wrap at depth, also for non power of two sizes
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == PTR_W'(`MBOX_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // pointers and fill count
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) wr_ptr <= next_ptr(wr_ptr);
      if (pop_i)  rd_ptr <= next_ptr(rd_ptr);
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;  // push only
        2'b01:   count <= count - 1'b1;  // pop only
        default: count <= count;         // none, or both at once
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i && !flush_i) mem[wr_ptr] <= data_i;
  end

  assign data_o  = mem[rd_ptr];
  assign usage_o = count;

endmodule

//--- design/mbox_pkg.sv
// mailbox package: register and response encodings plus the lite bus request/response structs
`include "mbox_defines.svh"

package mbox_pkg;

  // -------------------------------------------------------------------------
  // register indices, address bits [5:2]
  typedef enum logic [3:0] {
    MBOXW  = 4'd0,  // push into outgoing FIFO
    MBOXR  = 4'd1,  // pop from incoming FIFO
    STATUS = 4'd2,  // empty / full / threshold flags
    ERROR  = 4'd3,  // sticky error flags, clear on read
    WIRQT  = 4'd4,  // write fill threshold
    RIRQT  = 4'd5,  // read fill threshold
    IRQS   = 4'd6,  // irq status, write one to clear
    IRQEN  = 4'd7,  // irq enable mask
    IRQP   = 4'd8,  // irq pending (status & enable)
    CTRL   = 4'd9   // flush controls
  } reg_e;

  // response codes as on AXI-Lite
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } resp_e;

  typedef logic [`MBOX_DATA_W-1:0]  data_t;
  typedef logic [`MBOX_ADDR_W-1:0]  addr_t;
  typedef logic [`MBOX_USAGE_W-1:0] usage_t;

  // -------------------------------------------------------------------------
  // master -> slave
  typedef struct packed {
    logic  aw_valid;
    addr_t aw_addr;
    logic  w_valid;
    data_t w_data;   // always a full word, no strobes
    logic  b_ready;
    logic  ar_valid;
    addr_t ar_addr;
    logic  r_ready;
  } lite_req_t;

  // slave -> master
  typedef struct packed {
    logic  aw_ready;
    logic  w_ready;
    logic  b_valid;
    resp_e b_resp;
    logic  ar_ready;
    logic  r_valid;
    data_t r_data;
    resp_e r_resp;
  } lite_rsp_t;

endpackage

//--- design/mbox_port_regs.sv
// mailbox port: lite slave decoder, register file, irq logic and registered B/R responses
`timescale 1ns/1ps
`include "mbox_defines.svh"

module mbox_port_regs import mbox_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  lite_req_t req_i,
  output lite_rsp_t rsp_o,
  input  data_t     r_data_i,   // head of incoming FIFO
  input  usage_t    w_usage_i,  // fill of outgoing FIFO
  input  usage_t    r_usage_i,  // fill of incoming FIFO
  output logic      w_push_o,
  output data_t     w_data_o,
  output logic      w_flush_o,
  output logic      r_pop_o,
  output logic      r_flush_o,
  output logic      irq_o       // active high level
);

  // -------------------------------------------------------------------------
  // register state
  logic [1:0] error_q, error_d;  // [0] read empty, [1] write full
  usage_t     wirqt_q, wirqt_d;
  usage_t     rirqt_q, rirqt_d;
  logic [2:0] irqs_q,  irqs_d;   // [0] write thr, [1] read thr, [2] error
  logic [2:0] irqen_q, irqen_d;
  logic [2:0] irqp;
  logic [3:0] status;
  logic [1:0] err_set;           // error events this cycle
  logic       w_full, r_empty;

  // response slots
  logic  b_valid_q, r_valid_q;
  resp_e b_resp_q,  b_resp_d;
  resp_e r_resp_q,  r_resp_d;
  data_t r_data_q,  r_data_d;
  logic  wr_acc, rd_acc;
  logic  w_dec_ok, r_dec_ok;

  // word aligned, index in range, upper bits zero
  function automatic logic dec_ok(input addr_t addr);
    dec_ok = (addr[5:2] < `MBOX_NUM_REGS) && (addr[1:0] == 2'b00) &&
             (addr[`MBOX_ADDR_W-1:6] == '0);
  endfunction

  // thresholds saturate at depth - 1 so the irq can still fire when full
  function automatic usage_t clamp_thr(input data_t val);
    if (val >= data_t'(`MBOX_DEPTH)) clamp_thr = usage_t'(`MBOX_DEPTH - 1);
    else                             clamp_thr = val[`MBOX_USAGE_W-1:0];
  endfunction

  assign w_full  = (w_usage_i == usage_t'(`MBOX_DEPTH));
  assign r_empty = (r_usage_i == '0);
  assign status  = {r_usage_i > rirqt_q, w_usage_i > wirqt_q, w_full, r_empty};
  assign irqp    = irqs_q & irqen_q;
  assign irq_o   = |irqp;

  // a slot is free when empty or drained in this cycle
  assign wr_acc   = req_i.aw_valid && req_i.w_valid && (!b_valid_q || req_i.b_ready);
  assign rd_acc   = req_i.ar_valid && (!r_valid_q || req_i.r_ready);
  assign w_dec_ok = dec_ok(req_i.aw_addr);
  assign r_dec_ok = dec_ok(req_i.ar_addr);
  assign w_data_o = req_i.w_data;

  // -------------------------------------------------------------------------
  // register access, read and write share one block for the error/irqs merge
  always_comb begin
    error_d   = error_q;
    wirqt_d   = wirqt_q;
    rirqt_d   = rirqt_q;
    irqs_d    = irqs_q;
    irqen_d   = irqen_q;
    err_set   = 2'b00;
    w_push_o  = 1'b0;
    w_flush_o = 1'b0;
    r_pop_o   = 1'b0;
    r_flush_o = 1'b0;
    b_resp_d  = RESP_SLVERR;  // unmapped or read only
    r_resp_d  = RESP_SLVERR;
    r_data_d  = '0;

    // read side
    if (rd_acc && r_dec_ok) begin
      r_resp_d = RESP_OKAY;
      unique case (reg_e'(req_i.ar_addr[5:2]))
        MBOXW:  r_data_d = `MBOX_RD_WO;
        MBOXR: begin
          if (!r_empty) begin
            r_data_d = r_data_i;
            r_pop_o  = 1'b1;
          end else begin
            r_data_d   = `MBOX_RD_EMPTY;
            r_resp_d   = RESP_SLVERR;
            err_set[0] = 1'b1;
          end
        end
        STATUS: r_data_d = data_t'(status);
        ERROR: begin
          r_data_d = data_t'(error_q);
          error_d  = '0;                  // clear on read
        end
        WIRQT:  r_data_d = data_t'(wirqt_q);
        RIRQT:  r_data_d = data_t'(rirqt_q);
        IRQS:   r_data_d = data_t'(irqs_q);
        IRQEN:  r_data_d = data_t'(irqen_q);
        IRQP:   r_data_d = data_t'(irqp);
        CTRL:   r_data_d = '0;            // flush bits are pulses
        default: r_resp_d = RESP_SLVERR;
      endcase
    end

    // write side
    if (wr_acc && w_dec_ok) begin
      unique case (reg_e'(req_i.aw_addr[5:2]))
        MBOXW: begin
          if (!w_full) begin
            w_push_o = 1'b1;
            b_resp_d = RESP_OKAY;
          end else begin
            err_set[1] = 1'b1;            // dropped word, SLVERR stays
          end
        end
        WIRQT: begin
          wirqt_d  = clamp_thr(req_i.w_data);
          b_resp_d = RESP_OKAY;
        end
        RIRQT: begin
          rirqt_d  = clamp_thr(req_i.w_data);
          b_resp_d = RESP_OKAY;
        end
        IRQS: begin
          irqs_d   = irqs_q & ~req_i.w_data[2:0];  // write one to clear
          b_resp_d = RESP_OKAY;
        end
        IRQEN: begin
          irqen_d  = req_i.w_data[2:0];
          b_resp_d = RESP_OKAY;
        end
        CTRL: begin
          w_flush_o = req_i.w_data[0];
          r_flush_o = req_i.w_data[1];
          b_resp_d  = RESP_OKAY;
        end
        default: b_resp_d = RESP_SLVERR;  // MBOXR, STATUS, ERROR, IRQP
      endcase
    end

    // new events beat a clear in the same cycle
    error_d = error_d | err_set;
    irqs_d  = irqs_d | {|err_set, status[3], status[2]};
  end

  // -------------------------------------------------------------------------
  // control state
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      error_q   <= '0;
      wirqt_q   <= '0;
      rirqt_q   <= '0;
      irqs_q    <= '0;
      irqen_q   <= '0;
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      error_q <= error_d;
      wirqt_q <= wirqt_d;
      rirqt_q <= rirqt_d;
      irqs_q  <= irqs_d;
      irqen_q <= irqen_d;
      if (wr_acc)             b_valid_q <= 1'b1;
      else if (req_i.b_ready) b_valid_q <= 1'b0;
      if (rd_acc)             r_valid_q <= 1'b1;
      else if (req_i.r_ready) r_valid_q <= 1'b0;
    end
  end

  // response payload, only meaningful while valid
  always_ff @(posedge clk_i) begin
    if (wr_acc) b_resp_q <= b_resp_d;
    if (rd_acc) begin
      r_resp_q <= r_resp_d;
      r_data_q <= r_data_d;
    end
  end

  assign rsp_o.aw_ready = wr_acc;
  assign rsp_o.w_ready  = wr_acc;
  assign rsp_o.b_valid  = b_valid_q;
  assign rsp_o.b_resp   = b_resp_q;
  assign rsp_o.ar_ready = rd_acc;
  assign rsp_o.r_valid  = r_valid_q;
  assign rsp_o.r_data   = r_data_q;
  assign rsp_o.r_resp   = r_resp_q;

endmodule

//--- design/mbox_top.sv
// mailbox top: two lite slave ports cross-connected through two mailbox FIFOs
`timescale 1ns/1ps
`include "mbox_defines.svh"

module mbox_top import mbox_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  lite_req_t [1:0] req_i,   // index is port
  output lite_rsp_t [1:0] rsp_o,
  output logic      [1:0] irq_o    // one level irq per port
);

  // -------------------------------------------------------------------------
  // per port fifo controls, index is port
  logic  [1:0] w_push, w_flush, r_pop, r_flush;
  data_t [1:0] w_data, r_data;
  usage_t      usage_a2b, usage_b2a;  // a2b: port 0 -> port 1

  mbox_port_regs u_port0 (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .req_i     ( req_i[0]   ),
    .rsp_o     ( rsp_o[0]   ),
    .r_data_i  ( r_data[0]  ),
    .w_usage_i ( usage_a2b  ),  // writes into a2b
    .r_usage_i ( usage_b2a  ),  // reads out of b2a
    .w_push_o  ( w_push[0]  ),
    .w_data_o  ( w_data[0]  ),
    .w_flush_o ( w_flush[0] ),
    .r_pop_o   ( r_pop[0]   ),
    .r_flush_o ( r_flush[0] ),
    .irq_o     ( irq_o[0]   )
  );

  mbox_port_regs u_port1 (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .req_i     ( req_i[1]   ),
    .rsp_o     ( rsp_o[1]   ),
    .r_data_i  ( r_data[1]  ),
    .w_usage_i ( usage_b2a  ),
    .r_usage_i ( usage_a2b  ),
    .w_push_o  ( w_push[1]  ),
    .w_data_o  ( w_data[1]  ),
    .w_flush_o ( w_flush[1] ),
    .r_pop_o   ( r_pop[1]   ),
    .r_flush_o ( r_flush[1] ),
    .irq_o     ( irq_o[1]   )
  );

  // either end may flush a direction
  mbox_fifo u_fifo_a2b (
    .clk_i   ( clk_i                     ),
    .rst_n_i ( rst_n_i                   ),
    .flush_i ( w_flush[0] | r_flush[1]   ),
    .push_i  ( w_push[0]                 ),
    .data_i  ( w_data[0]                 ),
    .pop_i   ( r_pop[1]                  ),
    .data_o  ( r_data[1]                 ),
    .usage_o ( usage_a2b                 )
  );

  mbox_fifo u_fifo_b2a (
    .clk_i   ( clk_i                     ),
    .rst_n_i ( rst_n_i                   ),
    .flush_i ( w_flush[1] | r_flush[0]   ),
    .push_i  ( w_push[1]                 ),
    .data_i  ( w_data[1]                 ),
    .pop_i   ( r_pop[0]                  ),
    .data_o  ( r_data[0]                 ),
    .usage_o ( usage_b2a                 )
  );

endmodule

//--- include/mbox_defines.svh
// mailbox defines: bus widths, FIFO depth, register count and marker read words
`ifndef MBOX_DEFINES_SVH
`define MBOX_DEFINES_SVH

// bus geometry
`define MBOX_DATA_W   32      // data bus width
`define MBOX_ADDR_W   8       // byte address width, one small space per port

// mailbox FIFO sizing
`define MBOX_DEPTH    4       // entries per direction
`define MBOX_USAGE_W  3       // fill count 0..MBOX_DEPTH

// register map
`define MBOX_NUM_REGS 10      // MBOXW .. CTRL

// marker words returned on special reads
`define MBOX_RD_WO    32'hFEEDC0DE  // read of write-only MBOXW
`define MBOX_RD_EMPTY 32'hFEEDDEAD  // read of MBOXR while empty

`endif

//--- verification/mbox_tb.sv
// mailbox testbench driving lite bus traffic on both ports through data, error, irq, flush and stall cases
`timescale 1ns/1ps
`include "mbox_defines.svh"

module mbox_tb import mbox_pkg::*; ();

  localparam int TMO = 50;             // cycles allowed for any single wait

  logic            clk_i = 1'b0;
  logic            rst_n_i;
  lite_req_t [1:0] req;                // index is port
  lite_rsp_t [1:0] rsp;
  logic      [1:0] irq;
  int              errors = 0;
  int              checks = 0;
  data_t           exp_q[$];           // words in flight through one FIFO
  string           sig_name[5] = '{"aw_ready", "b_valid", "ar_ready", "r_valid", "irq_o"};

  always #4 clk_i = ~clk_i;            // 8 ns period

  mbox_top mbox_top_i (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .req_i   ( req     ),
    .rsp_o   ( rsp     ),
    .irq_o   ( irq     )
  );

  // a held B response must block new writes on that port
  for (genvar p = 0; p < 2; p++) begin : g_bp
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
                     (rsp[p].b_valid && !req[p].b_ready) |-> !rsp[p].aw_ready)
      else begin
        errors++;
        $display("[FAIL] %0t rsp_o[%0d].aw_ready expected 0 got 1", $time, p);
      end
  end

  // --------------------------------------------------------------------------
  // helpers
  task automatic check_val(input string name, input data_t got, input data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic abort_run(input string what);
    errors++;
    $display("timeout while waiting for %s", what);
    $display("checks %0d, errors %0d", checks, errors);
    $display("Verification failed");
    $finish;
  endtask

  function automatic addr_t reg_addr(input reg_e r);
    return {2'b00, r, 2'b00};          // word index in bits 5:2
  endfunction

  // 0 aw_ready, 1 b_valid, 2 ar_ready, 3 r_valid, 4 irq
  function automatic logic sig_of(input int p, input int which);
    case (which)
      0:       return rsp[p].aw_ready;
      1:       return rsp[p].b_valid;
      2:       return rsp[p].ar_ready;
      3:       return rsp[p].r_valid;
      default: return irq[p];
    endcase
  endfunction

  // poll at falling edges and count the extra cycles in n
  task automatic wait_high(input int p, input int which, output int n);
    n = 0;
    @(negedge clk_i);
    while (!sig_of(p, which) && n <= TMO) begin
      n++;
      @(negedge clk_i);
    end
    if (!sig_of(p, which)) abort_run($sformatf("%s on port %0d", sig_name[which], p));
  endtask

  task automatic bus_write(input int p, input addr_t addr, input data_t data, input resp_e exp);
    int n;
    @(posedge clk_i);
    req[p].aw_valid <= 1'b1;
    req[p].aw_addr  <= addr;
    req[p].w_valid  <= 1'b1;
    req[p].w_data   <= data;
    wait_high(p, 0, n);
    check_val($sformatf("rsp_o[%0d].w_ready", p), data_t'(rsp[p].w_ready), 1);
    @(posedge clk_i);                  // accept edge
    req[p].aw_valid <= 1'b0;
    req[p].w_valid  <= 1'b0;
    wait_high(p, 1, n);
    check_val("b_valid delay", n, 0);  // B valid one cycle after accept
    check_val($sformatf("rsp_o[%0d].b_resp", p), data_t'(rsp[p].b_resp), data_t'(exp));
    @(posedge clk_i);                  // B handshake with b_ready high
  endtask

  // read and compare the masked data word
  task automatic bus_read(input int p, input addr_t addr, input data_t exp, input resp_e exp_resp,
                          input data_t mask = '1);
    int n;
    @(posedge clk_i);
    req[p].ar_valid <= 1'b1;
    req[p].ar_addr  <= addr;
    wait_high(p, 2, n);
    @(posedge clk_i);
    req[p].ar_valid <= 1'b0;
    wait_high(p, 3, n);
    check_val("r_valid delay", n, 0);
    check_val($sformatf("rsp_o[%0d].r_data", p), rsp[p].r_data & mask, exp);
    check_val($sformatf("rsp_o[%0d].r_resp", p), data_t'(rsp[p].r_resp), data_t'(exp_resp));
    @(posedge clk_i);
  endtask

  task automatic push_words(input int p, input int k);
    data_t d;
    repeat (k) begin
      d = $urandom;
      exp_q.push_back(d);
      bus_write(p, reg_addr(MBOXW), d, RESP_OKAY);
    end
  endtask

  // pop every expected word in order on the reading port
  task automatic drain(input int p);
    while (exp_q.size() > 0) bus_read(p, reg_addr(MBOXR), exp_q.pop_front(), RESP_OKAY);
  endtask

  // --------------------------------------------------------------------------
  initial begin
    int    n;
    data_t wd;
    void'($urandom(26));
    rst_n_i = 1'b0;
    req     = '0;
    req[0].b_ready = 1'b1;
    req[1].b_ready = 1'b1;
    req[0].r_ready = 1'b1;
    req[1].r_ready = 1'b1;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;

    @(negedge clk_i);
    check_val("irq_o", data_t'(irq), 0);
    for (int p = 0; p < 2; p++) begin
      check_val($sformatf("rsp_o[%0d].b_valid", p), data_t'(rsp[p].b_valid), 0);
      check_val($sformatf("rsp_o[%0d].r_valid", p), data_t'(rsp[p].r_valid), 0);
      bus_read(p, reg_addr(STATUS), 1, RESP_OKAY);      // read FIFO empty
    end

    // data path in both directions keeps order
    for (int p = 0; p < 2; p++) begin
      push_words(p, `MBOX_DEPTH);
      drain(1 - p);
    end
    bus_read(0, reg_addr(MBOXW), `MBOX_RD_WO, RESP_OKAY);

    // full and empty errors
    push_words(0, `MBOX_DEPTH);
    bus_write(0, reg_addr(MBOXW), 32'h0BAD0BAD, RESP_SLVERR);  // dropped
    bus_read(0, reg_addr(ERROR), 2, RESP_OKAY);
    bus_read(0, reg_addr(ERROR), 0, RESP_OKAY);                // cleared by the read
    drain(1);
    bus_read(1, reg_addr(MBOXR), `MBOX_RD_EMPTY, RESP_SLVERR);
    bus_read(1, reg_addr(IRQS), 4, RESP_OKAY, 4);              // error irq bit only

    // threshold irq on port 0
    bus_write(0, reg_addr(WIRQT), 100, RESP_OKAY);
    bus_read(0, reg_addr(WIRQT), `MBOX_DEPTH - 1, RESP_OKAY);  // clamped
    bus_write(0, reg_addr(WIRQT), 1, RESP_OKAY);
    bus_write(0, reg_addr(IRQS), 7, RESP_OKAY);
    bus_write(0, reg_addr(IRQEN), 1, RESP_OKAY);
    @(negedge clk_i);
    check_val("irq_o[0]", data_t'(irq[0]), 0);
    push_words(0, 2);                  // usage 2 is above threshold 1
    wait_high(0, 4, n);
    bus_read(0, reg_addr(IRQP), 1, RESP_OKAY);
    drain(1);
    bus_write(0, reg_addr(IRQS), 1, RESP_OKAY);
    @(negedge clk_i);
    check_val("irq_o[0]", data_t'(irq[0]), 0);

    // read-side flush from port 1 leaves b2a untouched
    wd = $urandom;
    bus_write(1, reg_addr(MBOXW), wd, RESP_OKAY);
    push_words(0, 2);
    exp_q.delete();
    bus_write(1, reg_addr(CTRL), 2, RESP_OKAY);
    bus_read(0, reg_addr(MBOXR), wd, RESP_OKAY);
    bus_read(1, reg_addr(STATUS), 1, RESP_OKAY);

    // decode errors
    bus_write(0, 8'h40, 0, RESP_SLVERR);                       // upper bit set
    bus_read(0, 8'h28, 0, RESP_SLVERR);                        // index 10
    bus_write(0, reg_addr(STATUS), 0, RESP_SLVERR);            // read only

    // --------------------------------------------------------------------------
    // B back-pressure with a second write held behind the first response
    @(posedge clk_i);
    req[0].b_ready  <= 1'b0;
    req[0].aw_valid <= 1'b1;
    req[0].aw_addr  <= reg_addr(IRQEN);
    req[0].w_valid  <= 1'b1;
    req[0].w_data   <= 32'd6;
    wait_high(0, 0, n);
    @(posedge clk_i);
    req[0].w_data <= 32'd1;
    repeat (4) begin
      @(negedge clk_i);
      check_val("rsp_o[0].aw_ready", data_t'(rsp[0].aw_ready), 0);
      check_val("rsp_o[0].w_ready", data_t'(rsp[0].w_ready), 0);
      check_val("rsp_o[0].b_valid", data_t'(rsp[0].b_valid), 1);
    end
    @(posedge clk_i);
    req[0].b_ready <= 1'b1;            // first B drains and the second write goes in
    wait_high(0, 0, n);
    @(posedge clk_i);
    req[0].aw_valid <= 1'b0;
    req[0].w_valid  <= 1'b0;
    wait_high(0, 1, n);
    check_val("rsp_o[0].b_resp", data_t'(rsp[0].b_resp), data_t'(RESP_OKAY));
    @(posedge clk_i);
    bus_read(0, reg_addr(IRQEN), 1, RESP_OKAY);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) $display("Verification passed");
    else $display("Verification failed");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
design/mbox_pkg.sv
design/mbox_fifo.sv
design/mbox_port_regs.sv
design/mbox_top.sv
verification/mbox_tb.sv
